//--- files.f
verilog/vga_pkg.sv
verilog/vga_sync.sv
verilog/cell_buffer.sv
verilog/axil_cell_slave.sv
verilog/pixel_out.sv
verilog/vga_top.sv
test/tb_clk.sv
test/vga_chk.sv
test/vga_tb.sv

//--- run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f files.f --top-module vga_tb -o vga_sim

./obj_dir/vga_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    exit 1
fi
exit 0

//--- test/tb_clk.sv
`timescale 1ns/1ps

// free running 10 ns clock
module tb_clk (
    output logic clk0
);

    initial begin
        clk0 = 1'b0;
    end

    always #5 clk0 = ~clk0;

endmodule

//--- test/vga_chk.sv
`timescale 1ns/1ps

module vga_chk (
    input logic        clk0,
    input logic        rst_n,
    input logic [15:0] awaddr,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] wdata,
    input logic        wvalid,
    input logic        wready,
    input logic [15:0] araddr,
    input logic        arvalid,
    input logic        arready,
    input logic        h_sync,
    input logic        blank_n,
    input logic [3:0]  vga_r,
    input logic [3:0]  vga_g,
    input logic [3:0]  vga_b
);

    // clk0 cycles spent in the current h_sync pulse
    int hs_low;

    always_ff @(posedge clk0) begin
        hs_low <= h_sync ? 0 : hs_low + 1;
    end

    // master side holds valid and payload until ready
    aw_hold: assert property (@(posedge clk0) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr)) else $error("aw dropped");
    w_hold: assert property (@(posedge clk0) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata)) else $error("w dropped");
    ar_hold: assert property (@(posedge clk0) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr)) else $error("ar dropped");

    // 96 pixels at 2 clk0 each
    hs_width: assert property (@(posedge clk0) disable iff (!rst_n)
        $rose(h_sync) |-> hs_low == 192) else $error("h_sync width");

    black_in_blank: assert property (@(posedge clk0) disable iff (!rst_n)
        !blank_n |-> {vga_r, vga_g, vga_b} == 12'h000) else $error("rgb in blank");

endmodule

bind vga_top vga_chk chk_inst (.*);

//--- test/vga_patterns.txt
# w addr data strb bresp | r addr rdata rresp | p col row rgb
# c checks one frame of pixels, f checks the frame counter
w 4004 00000f00 f 0
w 4008 000000f0 f 0
w 400c 0000000f f 0
w 403c 00000abc f 0
w 403c 00000123 1 0
r 403c 00000a23 0
r 4004 00000f00 0
w 0000 00000001 1 0
w 3ffc 00000002 1 0
w 0104 0000000f 1 0
w 1000 00000003 1 0
w 5000 00000007 f 2
w 4040 00000005 f 2
r 0000 00000000 2
r 5000 00000000 2
p 0 0 f00
p 127 31 0f0
p 65 0 a23
p 0 8 00f
c
f

//--- test/vga_tb.sv
`timescale 1ns/1ps

module vga_tb;

    logic        clk0;
    logic        rst_n;
    logic [15:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [15:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;
    logic        h_sync;
    logic        v_sync;
    logic        blank_n;

    int mismatches = 0;
    int other_errs = 0;
    int seed = 48;
    // expected rgb per cell, bit 12 marks a checked cell
    logic [12:0] exp_rgb [4096];
    int n_exp = 0;
    int n_seen = 0;
    bit checking = 0;
    longint cyc = 0;
    longint hs_fall = 0;
    longint vs_fall = 0;
    longint bn_rise = 0;
    int vs_count = 0;
    int line = -1;
    int px = 0;
    logic hs_q = 1;
    logic vs_q = 1;
    logic bn_q = 0;

    tb_clk clk_gen (.clk0(clk0));

    vga_top vga_top_inst (.*);

    // 4 frames of 840000 cycles plus slack
    initial begin
        #((4 * 840000 + 20000) * 10);
        $display("watchdog expired before the test finished");
        $display("TEST FAILED");
        $finish;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    // random ready delay, 0 to 3 cycles
    task automatic ready_delay();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) @(negedge clk0);
    endtask

    task automatic axi_write(input logic [15:0] a, input logic [31:0] d,
                             input logic [3:0] s, input logic [1:0] er);
        awaddr  = a;
        wdata   = d;
        wstrb   = s;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk0);
        while (!awready) @(negedge clk0);
        // W is taken on the same edge as AW
        compare("wready", wready, 1);
        // handshake on the edge in between
        @(negedge clk0);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk0);
        ready_delay();
        bready = 1'b1;
        compare("bresp", bresp, er);
        @(negedge clk0);
        bready = 1'b0;
        if (bvalid) begin
            $display("write response to %h was given twice", a);
            other_errs++;
        end
    endtask

    task automatic axi_read(input logic [15:0] a, input logic [31:0] ed, input logic [1:0] er);
        araddr  = a;
        arvalid = 1'b1;
        @(negedge clk0);
        while (!arready) @(negedge clk0);
        @(negedge clk0);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk0);
        ready_delay();
        rready = 1'b1;
        compare("rresp", rresp, er);
        compare("rdata", rdata, ed);
        @(negedge clk0);
        rready = 1'b0;
        if (rvalid) begin
            $display("read response from %h was given twice", a);
            other_errs++;
        end
    endtask

    // one full frame between two v_sync falls
    task automatic check_frame();
        int n;
        n = vs_count;
        wait (vs_count == n + 1);
        checking = 1;
        n_seen   = 0;
        wait (vs_count == n + 2);
        checking = 0;
        // 10 cycles by 15 lines per cell
        if (n_seen != n_exp * 150) begin
            $display("only %0d of %0d expected pixel samples were seen", n_seen, n_exp * 150);
            other_errs++;
        end
    endtask

    // video monitor, samples at the falling edge
    always @(negedge clk0) begin
        cyc++;
        if (hs_q && !h_sync) begin
            if (hs_fall != 0) compare("h_sync period", 32'(cyc - hs_fall), 1600);
            hs_fall = cyc;
        end
        if (!hs_q && h_sync && hs_fall != 0) compare("h_sync low", 32'(cyc - hs_fall), 192);
        if (vs_q && !v_sync) begin
            if (vs_fall != 0) compare("v_sync period", 32'(cyc - vs_fall), 840000);
            vs_fall = cyc;
            vs_count++;
            line = -1;
        end
        if (!vs_q && v_sync && vs_fall != 0) compare("v_sync low", 32'(cyc - vs_fall), 3200);
        if (!bn_q && blank_n) begin
            bn_rise = cyc;
            line++;
            px = 0;
        end
        if (bn_q && !blank_n && bn_rise != 0) compare("blank_n high", 32'(cyc - bn_rise), 1280);
        if (blank_n) begin
            if (checking && line >= 0 && exp_rgb[(line / 15) * 128 + px / 10][12]) begin
                compare($sformatf("rgb col %0d row %0d", px / 10, line / 15), {vga_r, vga_g, vga_b},
                        exp_rgb[(line / 15) * 128 + px / 10][11:0]);
                n_seen++;
            end
            px++;
        end
        hs_q = h_sync;
        vs_q = v_sync;
        bn_q = blank_n;
    end

    initial begin
        int fd;
        int r;
        string cmd;
        string rest;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] s;
        logic [31:0] e;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        foreach (exp_rgb[i]) exp_rgb[i] = '0;
        repeat (2) @(negedge clk0);
        rst_n = 1'b1;
        // reset values still showing
        compare("h_sync", h_sync, 1);
        compare("v_sync", v_sync, 1);
        compare("blank_n", blank_n, 0);
        compare("rgb", {vga_r, vga_g, vga_b}, 0);
        compare("bvalid", bvalid, 0);
        compare("rvalid", rvalid, 0);
        fd = $fopen("test/vga_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                r = $fscanf(fd, "%s", cmd);
                if (r != 1) break;
                case (cmd)
                    "#": r = $fgets(rest, fd);
                    "w": begin
                        r = $fscanf(fd, "%h %h %h %h", a, d, s, e);
                        axi_write(a[15:0], d, s[3:0], e[1:0]);
                    end
                    "r": begin
                        r = $fscanf(fd, "%h %h %h", a, d, e);
                        axi_read(a[15:0], d, e[1:0]);
                    end
                    "p": begin
                        r = $fscanf(fd, "%d %d %h", a, d, e);
                        exp_rgb[d * 128 + a] = {1'b1, e[11:0]};
                        n_exp++;
                    end
                    "c": check_frame();
                    "f": begin
                        // counter steps at the frame wrap, ten lines before v_sync
                        @(posedge v_sync);
                        @(negedge clk0);
                        axi_read(16'h4040, 32'(vs_count - 1), 2'b00);
                    end
                    default: begin
                        $display("unknown pattern command %s", cmd);
                        other_errs++;
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/axil_cell_slave.sv
`timescale 1ns/1ps

module axil_cell_slave import vga_pkg::*; (
    input  logic       clk0,
    input  logic       rst_n,
    // write address and data
    input  axi_addr_t  awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axi_data_t  wdata,
    input  logic [3:0] wstrb,
    input  logic       wvalid,
    output logic       wready,
    // write response
    output logic [1:0] bresp,
    output logic       bvalid,
    input  logic       bready,
    // read address and data
    input  axi_addr_t  araddr,
    input  logic       arvalid,
    output logic       arready,
    output axi_data_t  rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready,
    // frame counting
    input  logic       frame_start,
    // cell memory writes
    output logic       cell_wr_en,
    output cell_addr_t cell_wr_addr,
    output color_idx_t cell_wr_data,
    // palette access
    output logic       pal_wr_en,
    output color_idx_t pal_wr_idx,
    output rgb_t       pal_wr_data,
    output logic [1:0] pal_wr_strb,
    output color_idx_t pal_rd_idx,
    input  rgb_t       pal_rd_data
);

    typedef enum logic {w_idle, w_resp} wr_state_t;
    typedef enum logic {r_idle, r_resp} rd_state_t;

    wr_state_t wr_state;
    rd_state_t rd_state;
    logic      wr_rdy;
    logic      rd_rdy;
    logic      wr_hs;
    logic      rd_hs;
    logic      aw_cell;
    logic      aw_pal;
    logic      ar_pal;
    logic      ar_frame;
    axi_data_t frame_cnt;

    // AW and W share one ready
    assign awready = wr_rdy;
    assign wready  = wr_rdy;
    assign arready = rd_rdy;
    assign bvalid  = (wr_state == w_resp);
    assign rvalid  = (rd_state == r_resp);

    assign wr_hs = wr_rdy && awvalid && wvalid;
    assign rd_hs = rd_rdy && arvalid;

    // address decode
    assign aw_cell  = (awaddr[15:14] == cell_base[15:14]);
    assign aw_pal   = (awaddr[15:6] == pal_base[15:6]);
    assign ar_pal   = (araddr[15:6] == pal_base[15:6]);
    assign ar_frame = (araddr[15:2] == frame_cnt_addr[15:2]);

    // writes land on the handshake edge, together with bvalid rising
    assign cell_wr_en   = wr_hs && aw_cell && wstrb[0];
    assign cell_wr_addr = awaddr[13:2];
    assign cell_wr_data = wdata[3:0];
    assign pal_wr_en    = wr_hs && aw_pal;
    assign pal_wr_idx   = awaddr[5:2];
    assign pal_wr_data  = wdata[11:0];
    assign pal_wr_strb  = wstrb[1:0];
    assign pal_rd_idx   = araddr[5:2];

    // write channel
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            wr_state <= w_idle;
            wr_rdy   <= 1'b0;
            bresp    <= resp_okay;
        end else begin
            // one cycle ready pulse once both channels are valid
            wr_rdy <= (wr_state == w_idle) && awvalid && wvalid && !wr_rdy;
            case (wr_state)
                w_idle: begin
                    if (wr_hs) begin
                        wr_state <= w_resp;
                        // frame counter is read only
                        bresp    <= (aw_cell || aw_pal) ? resp_okay : resp_slverr;
                    end
                end
                w_resp: begin
                    if (bready) begin
                        wr_state <= w_idle;
                    end
                end
                default: wr_state <= w_idle;
            endcase
        end
    end

    // read channel
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            rd_state <= r_idle;
            rd_rdy   <= 1'b0;
            rresp    <= resp_okay;
            rdata    <= '0;
        end else begin
            rd_rdy <= (rd_state == r_idle) && arvalid && !rd_rdy;
            case (rd_state)
                r_idle: begin
                    if (rd_hs) begin
                        rd_state <= r_resp;
                        if (ar_pal) begin
                            rresp <= resp_okay;
                            rdata <= axi_data_t'(pal_rd_data);
                        end else if (ar_frame) begin
                            rresp <= resp_okay;
                            rdata <= frame_cnt;
                        end else begin
                            // cell range has no readback
                            rresp <= resp_slverr;
                            rdata <= '0;
                        end
                    end
                end
                r_resp: begin
                    if (rready) begin
                        rd_state <= r_idle;
                    end
                end
                default: rd_state <= r_idle;
            endcase
        end
    end

    // frames since reset
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (frame_start) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

endmodule

//--- verilog/cell_buffer.sv
`timescale 1ns/1ps

module cell_buffer import vga_pkg::*; (
    input  logic       clk0,
    // bus side write port
    input  logic       wr_en,
    input  cell_addr_t wr_addr,
    input  color_idx_t wr_data,
    // display side read port
    input  cell_col_t  rd_col,
    input  cell_row_t  rd_row,
    output color_idx_t rd_data
);

    localparam int depth = cell_cols * cell_rows;

    // one palette index per cell, row major
    color_idx_t mem [depth];
    cell_addr_t rd_addr;

    // row * 128 + col is just the concatenation
    assign rd_addr = {rd_row, rd_col};

    // write port
    always_ff @(posedge clk0) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one clk0 of latency
    // read during write of the same cell returns the old value
    always_ff @(posedge clk0) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- verilog/pixel_out.sv
`timescale 1ns/1ps

module pixel_out import vga_pkg::*; (
    input  logic       clk0,
    input  logic       rst_n,
    input  color_idx_t cell_color,
    input  logic       h_sync_raw,
    input  logic       v_sync_raw,
    input  logic       blank_raw,
    // palette write from the bus
    input  logic       pal_wr_en,
    input  color_idx_t pal_wr_idx,
    input  rgb_t       pal_wr_data,
    input  logic [1:0] pal_wr_strb,
    // palette readback
    input  color_idx_t pal_rd_idx,
    output rgb_t       pal_rd_data,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       h_sync,
    output logic       v_sync,
    output logic       blank_n
);

    rgb_t palette [16];
    rgb_t rgb_q;
    // first delay stage, matches the cell buffer read
    logic h_sync_d;
    logic v_sync_d;
    logic blank_d;

    assign pal_rd_data = palette[pal_rd_idx];

    // palette register file, byte strobes
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                palette[i] <= '0;
            end
        end else if (pal_wr_en) begin
            if (pal_wr_strb[0]) begin
                palette[pal_wr_idx][7:0] <= pal_wr_data[7:0];
            end
            if (pal_wr_strb[1]) begin
                palette[pal_wr_idx][11:8] <= pal_wr_data[11:8];
            end
        end
    end

    // sync and blank through two flops, color lookup in the second
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            h_sync_d <= 1'b1;
            v_sync_d <= 1'b1;
            blank_d  <= 1'b1;
            h_sync   <= 1'b1;
            v_sync   <= 1'b1;
            blank_n  <= 1'b0;
            rgb_q    <= '0;
        end else begin
            h_sync_d <= h_sync_raw;
            v_sync_d <= v_sync_raw;
            blank_d  <= blank_raw;
            h_sync   <= h_sync_d;
            v_sync   <= v_sync_d;
            blank_n  <= ~blank_d;
            // black during blanking
            rgb_q    <= blank_d ? '0 : palette[cell_color];
        end
    end

    assign vga_r = rgb_q[11:8];
    assign vga_g = rgb_q[7:4];
    assign vga_b = rgb_q[3:0];

endmodule

//--- verilog/vga_pkg.sv
package vga_pkg;

    // horizontal timing in pixels, blanking first then active
    localparam int h_front_t  = 16;
    localparam int h_sync_t   = 96;
    localparam int h_back_t   = 48;
    localparam int h_active_t = 640;
    localparam int h_blank_t  = h_front_t + h_sync_t + h_back_t;
    localparam int h_total_t  = h_blank_t + h_active_t;

    // vertical timing in lines
    localparam int v_front_t  = 10;
    localparam int v_sync_t   = 2;
    localparam int v_back_t   = 33;
    localparam int v_active_t = 480;
    localparam int v_blank_t  = v_front_t + v_sync_t + v_back_t;
    localparam int v_total_t  = v_blank_t + v_active_t;

    // cell geometry, 640/5 by 480/15
    localparam int cell_w    = 5;
    localparam int cell_h    = 15;
    localparam int cell_cols = h_active_t / cell_w;
    localparam int cell_rows = v_active_t / cell_h;

    typedef logic [9:0]  scan_cnt_t;
    typedef logic [6:0]  cell_col_t;
    typedef logic [4:0]  cell_row_t;
    // row * 128 + col
    typedef logic [11:0] cell_addr_t;
    typedef logic [3:0]  color_idx_t;
    // r in [11:8], g in [7:4], b in [3:0]
    typedef logic [11:0] rgb_t;
    typedef logic [15:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;

    // register map, byte addresses
    localparam axi_addr_t cell_base      = 16'h0000;
    localparam axi_addr_t pal_base       = 16'h4000;
    localparam axi_addr_t frame_cnt_addr = 16'h4040;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

//--- verilog/vga_sync.sv
`timescale 1ns/1ps

module vga_sync import vga_pkg::*; (
    input  logic      clk0,
    input  logic      rst_n,
    output logic      pix_en,
    output logic      h_sync_raw,
    output logic      v_sync_raw,
    output logic      blank_raw,
    output cell_col_t cell_col,
    output cell_row_t cell_row,
    output logic      frame_start
);

    scan_cnt_t  h_cnt;
    scan_cnt_t  v_cnt;
    scan_cnt_t  h_next;
    scan_cnt_t  v_next;
    logic       line_end;
    logic       frame_end;
    // position inside the current cell
    logic [2:0] col_sub;
    logic [3:0] row_sub;

    // last pixel of a line, last line of a frame
    assign line_end  = (h_cnt == scan_cnt_t'(h_total_t - 1));
    assign frame_end = line_end && (v_cnt == scan_cnt_t'(v_total_t - 1));

    // next counter values, so the flops below describe the same pixel as the counters
    always_comb begin
        h_next = line_end ? '0 : h_cnt + 1'b1;
        v_next = v_cnt;
        if (line_end) begin
            v_next = (v_cnt == scan_cnt_t'(v_total_t - 1)) ? '0 : v_cnt + 1'b1;
        end
    end

    // half-rate pixel enable
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            pix_en <= 1'b0;
        end else begin
            pix_en <= ~pix_en;
        end
    end

    // scan counters plus registered syncs and blank
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            h_cnt      <= '0;
            v_cnt      <= '0;
            h_sync_raw <= 1'b1;
            v_sync_raw <= 1'b1;
            blank_raw  <= 1'b1;
        end else if (pix_en) begin
            h_cnt      <= h_next;
            v_cnt      <= v_next;
            // active low pulses
            h_sync_raw <= !((h_next >= h_front_t) && (h_next < h_front_t + h_sync_t));
            v_sync_raw <= !((v_next >= v_front_t) && (v_next < v_front_t + v_sync_t));
            blank_raw  <= (h_next < h_blank_t) || (v_next < v_blank_t);
        end
    end

    // single clk0 pulse at the frame wrap
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            frame_start <= 1'b0;
        end else begin
            frame_start <= pix_en && frame_end;
        end
    end

    // column steps every cell_w pixels of the active line
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            cell_col <= '0;
            col_sub  <= '0;
        end else if (pix_en) begin
            if (h_next == scan_cnt_t'(h_blank_t)) begin
                // first active pixel
                cell_col <= '0;
                col_sub  <= '0;
            end else if (h_next > scan_cnt_t'(h_blank_t)) begin
                if (col_sub == 3'(cell_w - 1)) begin
                    col_sub  <= '0;
                    cell_col <= cell_col + 1'b1;
                end else begin
                    col_sub <= col_sub + 1'b1;
                end
            end
        end
    end

    // row steps every cell_h lines, only at line wrap
    always_ff @(posedge clk0) begin
        if (!rst_n) begin
            cell_row <= '0;
            row_sub  <= '0;
        end else if (pix_en && line_end) begin
            if (v_next == scan_cnt_t'(v_blank_t)) begin
                cell_row <= '0;
                row_sub  <= '0;
            end else if (v_next > scan_cnt_t'(v_blank_t)) begin
                if (row_sub == 4'(cell_h - 1)) begin
                    row_sub  <= '0;
                    cell_row <= cell_row + 1'b1;
                end else begin
                    row_sub <= row_sub + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/vga_top.sv
`timescale 1ns/1ps

module vga_top import vga_pkg::*; (
    input  logic       clk0,
    input  logic       rst_n,
    // AXI4-Lite slave
    input  axi_addr_t  awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axi_data_t  wdata,
    input  logic [3:0] wstrb,
    input  logic       wvalid,
    output logic       wready,
    output logic [1:0] bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axi_addr_t  araddr,
    input  logic       arvalid,
    output logic       arready,
    output axi_data_t  rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready,
    // video
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       h_sync,
    output logic       v_sync,
    output logic       blank_n
);

    // scan side
    logic       h_sync_raw;
    logic       v_sync_raw;
    logic       blank_raw;
    cell_col_t  cell_col;
    cell_row_t  cell_row;
    logic       frame_start;
    color_idx_t cell_color;
    // bus side
    logic       cell_wr_en;
    cell_addr_t cell_wr_addr;
    color_idx_t cell_wr_data;
    logic       pal_wr_en;
    color_idx_t pal_wr_idx;
    rgb_t       pal_wr_data;
    logic [1:0] pal_wr_strb;
    color_idx_t pal_rd_idx;
    rgb_t       pal_rd_data;

    vga_sync vga_sync_inst (
        .clk0        (clk0),
        .rst_n       (rst_n),
        .pix_en      (),
        .h_sync_raw  (h_sync_raw),
        .v_sync_raw  (v_sync_raw),
        .blank_raw   (blank_raw),
        .cell_col    (cell_col),
        .cell_row    (cell_row),
        .frame_start (frame_start)
    );

    cell_buffer cell_buffer_inst (
        .clk0    (clk0),
        .wr_en   (cell_wr_en),
        .wr_addr (cell_wr_addr),
        .wr_data (cell_wr_data),
        .rd_col  (cell_col),
        .rd_row  (cell_row),
        .rd_data (cell_color)
    );

    axil_cell_slave axil_cell_slave_inst (
        .clk0         (clk0),
        .rst_n        (rst_n),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .frame_start  (frame_start),
        .cell_wr_en   (cell_wr_en),
        .cell_wr_addr (cell_wr_addr),
        .cell_wr_data (cell_wr_data),
        .pal_wr_en    (pal_wr_en),
        .pal_wr_idx   (pal_wr_idx),
        .pal_wr_data  (pal_wr_data),
        .pal_wr_strb  (pal_wr_strb),
        .pal_rd_idx   (pal_rd_idx),
        .pal_rd_data  (pal_rd_data)
    );

    pixel_out pixel_out_inst (
        .clk0        (clk0),
        .rst_n       (rst_n),
        .cell_color  (cell_color),
        .h_sync_raw  (h_sync_raw),
        .v_sync_raw  (v_sync_raw),
        .blank_raw   (blank_raw),
        .pal_wr_en   (pal_wr_en),
        .pal_wr_idx  (pal_wr_idx),
        .pal_wr_data (pal_wr_data),
        .pal_wr_strb (pal_wr_strb),
        .pal_rd_idx  (pal_rd_idx),
        .pal_rd_data (pal_rd_data),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .h_sync      (h_sync),
        .v_sync      (v_sync),
        .blank_n     (blank_n)
    );

endmodule
